/* sim.f */
hw/pov_pkg.sv
hw/index_sensor.sv
hw/angle_tracker.sv
hw/column_buffer.sv
hw/led_shifter.sv
hw/pov_top.sv
testbench/tb_clock.sv
testbench/pov_tb.sv

/* Makefile */
# Verilator flow for the POV display testbench

VERILATOR ?= verilator
TOP       ?= pov_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/pov_tb.sv */
`timescale 1ns/1ps

module pov_tb;

    localparam int GAPS           = 10;   // pin rise spacings with a known length
    localparam int LEAD_CYCLES    = 1200; // idle pin before the first rise keeps early sectors long
    localparam int PIN_HIGH       = 40;   // width of one index pulse on the pin
    localparam int TAIL_CYCLES    = 300;  // time after the last rise for its strobe and columns
    localparam int TIMEOUT_MARGIN = 2000;

    // the 2048 gap between pin rises slows the rotor so sector 15 is held
    localparam int REV_GAP [GAPS] = '{1024, 1280, 768, 1024, 1024, 2048, 1024, 1280, 1024, 1024};

    logic                            clk_in;
    logic                            rst_in;
    logic                            ir_pin;
    logic                            fb_write_valid;
    pov_pkg::frame_write_t           fb_write;
    logic [pov_pkg::COUNT_BITS-1:0]  rev_period;
    logic                            rev_valid;
    logic [pov_pkg::SECTOR_BITS-1:0] sector;
    logic                            led_data;
    logic                            led_clk;
    logic                            led_latch;

    logic [pov_pkg::LED_COUNT-1:0] frame_model [pov_pkg::SECTORS]; // what the host has written
    logic [pov_pkg::LED_COUNT-1:0] column_q [$]; // expected words in the order they shift out
    logic [pov_pkg::LED_COUNT-1:0] led_word;      // bits collected from the serial line
    logic [pov_pkg::LED_COUNT-1:0] expected_word;
    logic [31:0]                   rng_state;
    logic                          led_clk_prev = 1'b0;
    int rev_num        = 0; // rev_valid pulses seen so far
    int last_sector    = 0;
    int run_len        = 0; // cycles the current sector has been shown
    int sector_len_exp = 0; // 0 while the sector length is not known
    int bits_seen      = 0;
    int latch_count    = 0;
    int cycle_count    = 0;

    tb_clock i_tb_clock (
        .clk (clk_in)
    );

    pov_top i_pov_top (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .ir_pin         (ir_pin),
        .fb_write_valid (fb_write_valid),
        .fb_write       (fb_write),
        .rev_period     (rev_period),
        .rev_valid      (rev_valid),
        .sector         (sector),
        .led_data       (led_data),
        .led_clk        (led_clk),
        .led_latch      (led_latch)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223; // full period modulo 2^32
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = lcg_next(rng_state); // only the stimulus process draws numbers
        return rng_state;
    endfunction

    // rev_valid k closes the gap that began at pin rise k-1
    function automatic int expected_period(input int k);
        return REV_GAP[k-1];
    endfunction

    function automatic int expected_sector_len(input int k);
        if (k == 0) begin
            return 0; // the first period runs from reset, so its sectors are not checked
        end
        return REV_GAP[k-1] >> pov_pkg::SECTOR_BITS;
    endfunction

    function automatic logic [pov_pkg::LED_COUNT-1:0] expected_column(input int s);
        return frame_model[s];
    endfunction

    function automatic int total_cycles();
        int sum;
        sum = 10 + pov_pkg::SECTORS + LEAD_CYCLES + TAIL_CYCLES; // reset, frame load, lead, tail
        for (int i = 0; i < GAPS; i++) begin
            sum += REV_GAP[i];
        end
        return sum;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input int got, input int exp);
        fail_run($sformatf("[FAIL] %s: got %h expected %h", name, got, exp));
    endtask

    // the model takes the new pixels once the edge has committed the host write
    task automatic write_column(input int addr, input logic [pov_pkg::LED_COUNT-1:0] pixels);
        fb_write_valid  = 1'b1;
        fb_write.addr   = pov_pkg::SECTOR_BITS'(addr);
        fb_write.pixels = pixels;
        @(posedge clk_in);
        #1;
        frame_model[addr] = pixels;
        fb_write_valid    = 1'b0;
    endtask

    task automatic load_frame();
        int order [pov_pkg::SECTORS];
        int pick;
        int tmp;
        for (int i = 0; i < pov_pkg::SECTORS; i++) begin
            order[i] = i;
        end
        for (int i = pov_pkg::SECTORS - 1; i > 0; i--) begin
            pick        = int'(next_random() >> 16) % (i + 1); // shuffle the write order
            tmp         = order[i];
            order[i]    = order[pick];
            order[pick] = tmp;
        end
        for (int i = 0; i < pov_pkg::SECTORS; i++) begin
            write_column(order[i], pov_pkg::LED_COUNT'(next_random() >> 8));
        end
    endtask

    // one pin rise followed by gap-1 cycles with glitches and optional host writes
    task automatic run_revolution(input int gap, input bit live);
        int drop_at;
        int drop_len;
        int pulse_at;
        int pulse_len;
        int w;
        int write_at [2];
        int write_sector [2];
        logic [31:0] r;
        r         = next_random();
        drop_at   = 10 + int'(r[3:0]) % 10; // inside the high part of the index pulse
        drop_len  = r[4] ? 1 + int'(r[7:6]) % 3 : 0;
        pulse_at  = 100 + int'(r[31:16]) % 300; // well clear of both rises
        pulse_len = r[5] ? 1 + int'(r[9:8]) % 3 : 0;
        r               = next_random();
        write_at[0]     = live ? 50 + int'(r[15:0]) % 300 : -1;
        write_at[1]     = live ? write_at[0] + 350 : -1;
        write_sector[0] = int'(r[19:16]);
        write_sector[1] = int'(r[23:20]);
        for (int c = 0; c < gap; c++) begin
            ir_pin = (c < PIN_HIGH && !(c >= drop_at && c < drop_at + drop_len))
                     || (c >= pulse_at && c < pulse_at + pulse_len);
            if (c == write_at[0] || c == write_at[1]) begin
                w = (c == write_at[0]) ? 0 : 1;
                write_column(write_sector[w], pov_pkg::LED_COUNT'(next_random() >> 8));
            end else begin
                @(posedge clk_in);
                #1; // inputs move just after the edge
            end
        end
    endtask

    initial begin
        rst_in         = 1'b1;
        ir_pin         = 1'b0;
        fb_write_valid = 1'b0;
        fb_write       = '0;
        rng_state      = 32'ha5c4_f73d;
        repeat (10) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        load_frame(); // the frame memory powers up unknown
        repeat (LEAD_CYCLES) begin
            @(posedge clk_in);
            #1;
        end
        for (int i = 0; i < GAPS; i++) begin
            run_revolution(REV_GAP[i], i >= 2); // host rewrites columns once the rotor runs
        end
        run_revolution(TAIL_CYCLES, 1'b0); // the last rise closes the final gap
        assert (rev_num == GAPS + 1)
            else report_value("rev_valid count", rev_num, GAPS + 1);
        // every column read on a sector change has to have reached the latch by now
        assert (column_q.size() == 0)
            else fail_run($sformatf("%0d columns were never latched after %0d latches",
                                    column_q.size(), latch_count));
        $display("Simulation finished: PASS");
        $finish;
    end

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count > total_cycles() + TIMEOUT_MARGIN) begin
            fail_run($sformatf("timeout after %0d cycles, stimulus did not complete", cycle_count));
        end
    end

    // outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk_in) begin
        if (!rst_in) begin
            if (rev_valid) begin
                if (rev_num >= 1) begin
                    assert (int'(rev_period) == expected_period(rev_num))
                        else report_value("rev_period", int'(rev_period), expected_period(rev_num));
                end
                // a revolution longer than 15 sectors has to end parked on sector 15
                if (sector_len_exp != 0 && expected_period(rev_num) > 15 * sector_len_exp) begin
                    assert (last_sector == pov_pkg::SECTORS - 1)
                        else report_value("sector", last_sector, pov_pkg::SECTORS - 1);
                end
                assert (sector == '0) else report_value("sector", int'(sector), 0);
                sector_len_exp = expected_sector_len(rev_num);
                rev_num++;
                last_sector = 0;
                run_len     = 1;
                column_q.push_back(expected_column(0)); // the index also reads a column
            end else if (int'(sector) != last_sector) begin
                assert (int'(sector) == last_sector + 1)
                    else report_value("sector", int'(sector), last_sector + 1);
                if (sector_len_exp != 0) begin
                    assert (run_len == sector_len_exp)
                        else report_value("sector cycles", run_len, sector_len_exp);
                end
                last_sector = int'(sector);
                run_len     = 1;
                column_q.push_back(expected_column(last_sector));
            end else begin
                run_len++;
            end

            if (led_clk && !led_clk_prev) begin
                led_word = {led_word[pov_pkg::LED_COUNT-2:0], led_data}; // msb arrives first
                bits_seen++;
            end
            if (led_latch) begin
                assert (column_q.size() > 0)
                    else fail_run("led_latch pulsed with no column waiting to be shown");
                assert (bits_seen == pov_pkg::LED_COUNT)
                    else fail_run($sformatf("latch came after %0d led_clk pulses", bits_seen));
                expected_word = column_q.pop_front();
                assert (led_word == expected_word)
                    else report_value("led_data word", int'(led_word), int'(expected_word));
                latch_count++;
                bits_seen = 0;
            end
            led_clk_prev = led_clk;
        end
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk // free-running test clock, 40 ns period
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk; // half of the 40 ns period
        end
    end

endmodule

/* hw/pov_top.sv */
`timescale 1ns/1ps

module pov_top (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            ir_pin,         // raw index sensor
    input  logic                            fb_write_valid, // host frame write strobe
    input  pov_pkg::frame_write_t           fb_write,
    output logic [pov_pkg::COUNT_BITS-1:0]  rev_period,     // last measured revolution
    output logic                            rev_valid,
    output logic [pov_pkg::SECTOR_BITS-1:0] sector,         // current angular sector
    output logic                            led_data,       // to the LED driver chain
    output logic                            led_clk,
    output logic                            led_latch
);

    logic             index_strobe;  // clean rotor index
    logic             sector_strobe; // sector just changed
    logic             column_valid;  // column read from the frame memory
    pov_pkg::column_t column;

    index_sensor i_index_sensor (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .ir_pin       (ir_pin),
        .index_strobe (index_strobe)
    );

    angle_tracker i_angle_tracker (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .index_strobe  (index_strobe),
        .sector        (sector),
        .sector_strobe (sector_strobe),
        .rev_period    (rev_period),
        .rev_valid     (rev_valid)
    );

    column_buffer i_column_buffer (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .fb_write_valid (fb_write_valid),
        .fb_write       (fb_write),
        .sector         (sector),
        .sector_strobe  (sector_strobe),
        .column_valid   (column_valid),
        .column         (column)
    );

    led_shifter i_led_shifter (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .column_valid (column_valid),
        .column       (column),
        .led_data     (led_data),
        .led_clk      (led_clk),
        .led_latch    (led_latch)
    );

endmodule

/* hw/led_shifter.sv */
`timescale 1ns/1ps

module led_shifter (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             column_valid, // a new column to display
    input  pov_pkg::column_t column,
    output logic             led_data,     // serial pixel, msb first
    output logic             led_clk,      // driver samples led_data on the rising edge
    output logic             led_latch     // one cycle after the 16th bit
);

    logic [pov_pkg::LED_COUNT-1:0]         shift_reg;    // msb is the bit on led_data
    logic [pov_pkg::LED_COUNT-1:0]         pend_pixels;  // column waiting for the current shift
    logic                                  pend_full;    // pend_pixels holds a column
    logic                                  busy;         // a shift is putting bits out
    logic                                  phase;        // 0 while led_clk is low, 1 while high
    logic [$clog2(pov_pkg::LED_COUNT)-1:0] bit_cnt;      // index of the bit on the wire
    logic                                  load_start;   // a shift begins at this edge
    logic                                  bit_done;     // current bit has had both clock phases
    logic                                  last_bit;     // and it was the 16th one
    logic [pov_pkg::LED_COUNT-1:0]         start_pixels; // column the next shift uses

    // the latch cycle counts as idle, so a pending column starts right after it
    assign load_start   = ~busy & (column_valid | pend_full);
    assign start_pixels = column_valid ? column.pixels : pend_pixels; // newest column wins
    assign bit_done     = busy & phase;
    assign last_bit     = bit_done & (bit_cnt == $clog2(pov_pkg::LED_COUNT)'(pov_pkg::LED_COUNT - 1));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy      <= 1'b0;
            phase     <= 1'b0;
            bit_cnt   <= '0;
            pend_full <= 1'b0;
            led_data  <= 1'b0;
            led_clk   <= 1'b0;
            led_latch <= 1'b0;
        end else begin
            led_latch <= 1'b0;

            if (load_start) begin
                busy      <= 1'b1;
                phase     <= 1'b0;
                bit_cnt   <= '0;
                pend_full <= 1'b0; // the slot either started or got replaced
                led_data  <= start_pixels[pov_pkg::LED_COUNT-1];
                led_clk   <= 1'b0;
            end else if (busy) begin
                if (column_valid) begin
                    pend_full <= 1'b1; // park it until this shift is done
                end
                if (!phase) begin
                    phase   <= 1'b1;
                    led_clk <= 1'b1; // second half of the bit
                end else begin
                    phase   <= 1'b0;
                    led_clk <= 1'b0;
                    if (last_bit) begin
                        busy      <= 1'b0;
                        led_latch <= 1'b1; // 33rd cycle of the shift
                        led_data  <= 1'b0;
                    end else begin
                        bit_cnt  <= bit_cnt + 1'b1;
                        led_data <= shift_reg[pov_pkg::LED_COUNT-2]; // next bit down
                    end
                end
            end
        end
    end

    // pixel storage only moves under the control above
    always_ff @(posedge clk_in) begin
        if (load_start) begin
            shift_reg <= start_pixels;
        end else if (bit_done && !last_bit) begin
            shift_reg <= shift_reg << 1;
        end
        if (busy && column_valid) begin
            pend_pixels <= column.pixels; // a later arrival overwrites the slot
        end
    end

endmodule

/* hw/column_buffer.sv */
`timescale 1ns/1ps

module column_buffer (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            fb_write_valid, // host write strobe
    input  pov_pkg::frame_write_t           fb_write,       // sector and pixels to store
    input  logic [pov_pkg::SECTOR_BITS-1:0] sector,         // sector the bar has just entered
    input  logic                            sector_strobe,  // read request
    output logic                            column_valid,   // one cycle after sector_strobe
    output pov_pkg::column_t                column          // pixels for the sector, tagged
);

    // one column of pixels per sector, left as it was at power up
    logic [pov_pkg::LED_COUNT-1:0] frame_mem [pov_pkg::SECTORS];

    always_ff @(posedge clk_in) begin
        if (fb_write_valid) begin
            frame_mem[fb_write.addr] <= fb_write.pixels; // writes never stall
        end
    end

    // a read that hits the sector being written in the same cycle sees the old
    // pixels, since both sides sample on the same edge
    always_ff @(posedge clk_in) begin
        if (sector_strobe) begin
            column.pixels <= frame_mem[sector];
            column.sector <= sector; // tag so the column can be traced downstream
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            column_valid <= 1'b0;
        end else begin
            column_valid <= sector_strobe; // data and strobe land on the same edge
        end
    end

    // the host can rewrite any sector while the rotor spins, and the change
    // shows up the next time the bar reaches that sector

endmodule

/* hw/angle_tracker.sv */
`timescale 1ns/1ps

module angle_tracker (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            index_strobe, // rotor passed the sensor
    output logic [pov_pkg::SECTOR_BITS-1:0] sector,        // current angular sector
    output logic                            sector_strobe, // high in the first cycle of a new sector
    output logic [pov_pkg::COUNT_BITS-1:0]  rev_period,    // cycles in the last revolution
    output logic                            rev_valid      // rev_period was just updated
);

    logic [pov_pkg::COUNT_BITS-1:0] rev_count;         // cycles since the last index, minus one
    logic [pov_pkg::COUNT_BITS-1:0] period_next;       // cycles since the last index
    logic [pov_pkg::COUNT_BITS-1:0] cps_next;          // sector length from the period just ended
    logic [pov_pkg::COUNT_BITS-1:0] cycles_per_sector; // sector length for this revolution
    logic [pov_pkg::COUNT_BITS-1:0] countdown;         // cycles left in the current sector, minus one

    assign period_next = rev_count + 1'b1;
    assign cps_next    = period_next >> pov_pkg::SECTOR_BITS; // period divided by 16

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rev_count         <= '0;
            cycles_per_sector <= '0; // no rotation seen yet, so the sector is pinned at 0
            countdown         <= '0;
            sector            <= '0;
            sector_strobe     <= 1'b0;
            rev_valid         <= 1'b0;
        end else begin
            sector_strobe <= 1'b0;
            rev_valid     <= 1'b0;

            if (index_strobe) begin
                // the index locks the display back to sector 0 every revolution
                rev_count         <= '0;
                rev_valid         <= 1'b1;
                cycles_per_sector <= cps_next;
                countdown         <= cps_next - 1'b1; // first step comes cps_next cycles later
                sector            <= '0;
                sector_strobe     <= 1'b1;
            end else begin
                // hold near the top of the range so a stalled rotor can't wrap the period
                if (~&period_next) begin
                    rev_count <= period_next;
                end

                // a slowing rotor parks on the last sector until the next index
                if (cycles_per_sector != '0 && sector != pov_pkg::SECTOR_BITS'(pov_pkg::SECTORS - 1)) begin
                    if (countdown == '0) begin
                        sector        <= sector + 1'b1;
                        sector_strobe <= 1'b1;
                        countdown     <= cycles_per_sector - 1'b1; // reload for the next sector
                    end else begin
                        countdown <= countdown - 1'b1;
                    end
                end
            end
        end
    end

    // the measured period only moves together with rev_valid
    always_ff @(posedge clk_in) begin
        if (index_strobe) begin
            rev_period <= period_next; // count plus one, the whole revolution
        end
    end

    // with period P the sectors last P >> 4 cycles each, and the remainder of P
    // stretches sector 15 up to the next index

endmodule

/* hw/index_sensor.sv */
`timescale 1ns/1ps

module index_sensor (
    input  logic clk_in,
    input  logic rst_in,
    input  logic ir_pin,      // raw and asynchronous to clk_in
    output logic index_strobe // one cycle per clean rising edge
);

    logic sync_1; // first synchronizer stage, may go metastable
    logic sync_2; // second stage, safe to use from here on
    logic [pov_pkg::DEBOUNCE_BITS-1:0] agree_cnt; // samples in a row that differ from clean_level
    logic clean_level; // debounced sensor level
    logic clean_prev;  // clean_level one cycle later, for edge detection

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sync_1       <= 1'b0;
            sync_2       <= 1'b0;
            agree_cnt    <= '0;
            clean_level  <= 1'b0;
            clean_prev   <= 1'b0;
            index_strobe <= 1'b0;
        end else begin
            sync_1 <= ir_pin;
            sync_2 <= sync_1;

            // a run of DEBOUNCE_CYCLES differing samples moves the clean level
            // and any sample that matches it again throws the run away
            if (sync_2 != clean_level) begin
                if (agree_cnt == pov_pkg::DEBOUNCE_BITS'(pov_pkg::DEBOUNCE_CYCLES - 1)) begin
                    clean_level <= sync_2; // run complete, accept the new level
                    agree_cnt   <= '0;
                end else begin
                    agree_cnt <= agree_cnt + 1'b1;
                end
            end else begin
                agree_cnt <= '0; // glitch too short, the level stays
            end

            clean_prev   <= clean_level;
            index_strobe <= clean_level & ~clean_prev; // registered, so latency is fixed
        end
    end

    // total latency from a stable pin rise is 2 sync + DEBOUNCE_CYCLES + 1 edge stage,
    // so strobe spacing matches the spacing of the real pin edges

endmodule

/* hw/pov_pkg.sv */
package pov_pkg;

    // the bar sweeps 16 angular sectors per revolution
    localparam int SECTOR_BITS = 4; // width of a sector index
    localparam int SECTORS     = 1 << SECTOR_BITS; // 16 sectors

    localparam int LED_COUNT = 16; // one on/off pixel per LED on the bar

    // revolution counters are 20 bits, which covers about 1M cycles per turn
    localparam int COUNT_BITS = 20;

    // the clean sensor level only moves after this many agreeing samples
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int DEBOUNCE_BITS   = $clog2(DEBOUNCE_CYCLES); // counts 0 to DEBOUNCE_CYCLES-1

    // one host write into the frame memory
    typedef struct packed {
        logic [SECTOR_BITS-1:0] addr;   // sector being written
        logic [LED_COUNT-1:0]   pixels; // msb is the first pixel shifted out
    } frame_write_t;

    // a column read from the frame memory on a sector change
    typedef struct packed {
        logic [SECTOR_BITS-1:0] sector; // sector the pixels belong to
        logic [LED_COUNT-1:0]   pixels; // same bit order as frame_write_t
    } column_t;

    // both structs come out at 20 bits
    localparam int FRAME_WRITE_BITS = $bits(frame_write_t);
    localparam int COLUMN_BITS      = $bits(column_t);

endpackage
